//--- Makefile
VERILATOR ?= verilator
TOP       ?= phy_link_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+verilog
verilog/phy_link_pkg.sv
verilog/rx_align_if.sv
verilog/bit_counter.sv
verilog/par_to_serial.sv
verilog/serial_to_par.sv
verilog/rx_sync_fsm.sv
verilog/phy_link.sv
tests/tb_clock_gen.sv
tests/phy_link_props.sv
tests/phy_link_tb.sv

//--- tests/phy_link_patterns.txt
# columns: loop delay, byte count, then the data bytes, all in hex
# data bytes never use the comma value bc
0 4 11 22 33 44
1 5 a5 5a 00 ff 01
2 3 80 7f 3c
3 6 de ad be ef 12 34
4 2 bd bb
5 8 01 02 04 08 10 20 40 80
6 4 fe dc ba 98
7 5 c3 3c 96 69 0f
3 1 55
0 7 aa 99 88 77 66 65 f0

//--- tests/phy_link_props.sv
`timescale 1ns/10ps
`default_nettype none

module phy_link_props (
    input logic                      clk_32f,
    input logic                      reset,
    input phy_link_pkg::sync_state_t state,
    input logic                      realign,
    input logic                      byte_tick,
    input logic                      valid_out,
    input logic                      active
);

    import phy_link_pkg::*;

    // data only leaves a locked receiver
    valid_needs_active: assert property (@(posedge clk_32f) disable iff (reset)
        valid_out |-> active)
        else $error("valid_out high while not active");

    // single cycle pulse that moves the hunt into the check
    realign_in_hunt: assert property (@(posedge clk_32f) disable iff (reset)
        realign |-> (state == sync_hunt) ##1 (!realign && (state == sync_check)))
        else $error("realign outside sync_hunt or not a single pulse");

    // boundary must not move once locked
    tick_spacing: assert property (@(posedge clk_32f) disable iff (reset)
        (active && byte_tick) |=> (!byte_tick) [*7] ##1 byte_tick)
        else $error("receive byte_tick spacing broken while active");

endmodule

bind rx_sync_fsm phy_link_props props (
    .clk_32f   (clk_32f),
    .reset     (reset),
    .state     (state),
    .realign   (align.realign),
    .byte_tick (align.byte_tick),
    .valid_out (valid_out),
    .active    (active)
);

`default_nettype wire

//--- tests/phy_link_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "phy_link_defines.svh"

module phy_link_tb;

    localparam logic [7:0] COMMA = 8'hBC;

    logic       clk_32f;
    logic       por_reset;
    logic       test_reset = 1'b1;
    logic       dut_reset;
    logic [7:0] data_in = 8'h00;
    logic       valid_in = 1'b0;
    logic       serial_out;
    logic       serial_in;
    logic [7:0] data_out;
    logic       valid_out;
    logic       active;
    logic [2:0] loop_delay = 3'd0;
    logic [6:0] loop_pipe = '0;

    int         cyc = 0;
    int         clk_cycles = 0;
    int         errors = 0;
    int         checks = 0;
    int         rx_count = 0;
    int         last_pulse = -100;
    int         active_cyc = 0;
    bit         active_seen = 0;
    longint     watchdog_ns = 0;
    logic [7:0] exp_q[$];

    tb_clock_gen clock_gen (
        .clk_32f (clk_32f),
        .reset   (por_reset)
    );

    assign dut_reset = por_reset | test_reset;

    phy_link dut (
        .clk_32f    (clk_32f),
        .reset      (dut_reset),
        .data_in    (data_in),
        .valid_in   (valid_in),
        .serial_out (serial_out),
        .serial_in  (serial_in),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .active     (active)
    );

    //////////////////////////////
    // loopback delay line
    //////////////////////////////

    always @(posedge clk_32f) begin
        loop_pipe <= {loop_pipe[5:0], serial_out};
    end

    assign serial_in = (loop_delay == 3'd0) ? serial_out : loop_pipe[loop_delay - 3'd1];

    // cycles since reset release
    // tx byte slot starts where this is a multiple of 8
    always @(posedge clk_32f) begin
        clk_cycles <= clk_cycles + 1;
        if (dut_reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    //////////////////////////////
    // receive monitor
    //////////////////////////////

    always @(negedge clk_32f) begin
        if (!dut_reset && active && !active_seen) begin
            active_seen = 1;
            active_cyc = cyc;
        end
        if (!dut_reset && valid_out) begin
            checks++;
            rx_count++;
            if (clk_cycles - last_pulse < 8) begin
                $display("valid_out pulses only %0d cycles apart at %0t",
                         clk_cycles - last_pulse, $time);
                errors++;
            end
            last_pulse = clk_cycles;
            if (exp_q.size() == 0) begin
                $display("unexpected valid_out pulse at %0t, data_out %h", $time, data_out);
                errors++;
            end else begin
                if (data_out !== exp_q[0]) begin
                    $display("ERR %0t data_out got %h expected %h", $time, data_out, exp_q[0]);
                    errors++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    // drive one byte slot from the edge that starts it
    task automatic send_slot(input logic v, input logic [7:0] d);
        begin
            do begin
                @(posedge clk_32f);
            end while (cyc % 8 != 7);
            valid_in <= v;
            data_in  <= d;
        end
    endtask

    initial begin
        int         fd;
        int         code;
        int         d;
        int         n;
        int         b;
        int         pos;
        int         idle;
        int         wait_cnt;
        int         err_start;
        int         max_burst;
        string      line;
        int         test_delay[$];
        int         test_len[$];
        logic [7:0] test_bytes[$];

        code = $urandom(46);
        max_burst = 0;
        fd = $fopen("tests/phy_link_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/phy_link_patterns.txt");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            // two header lines describe the columns
            code = $fgets(line, fd);
            code = $fgets(line, fd);
            while ($fscanf(fd, "%h %h", d, n) == 2) begin
                test_delay.push_back(d);
                test_len.push_back(n);
                if (n > max_burst) begin
                    max_burst = n;
                end
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", b);
                    test_bytes.push_back(8'(b));
                end
            end
            $fclose(fd);
            watchdog_ns = longint'(test_delay.size()) * (max_burst + 20) * 8 * 4 * 40;

            wait (!por_reset);
            pos = 0;
            for (int t = 0; t < test_delay.size(); t++) begin
                err_start = errors;
                @(posedge clk_32f);
                test_reset <= 1'b1;
                valid_in   <= 1'b0;
                data_in    <= 8'h00;
                loop_delay <= 3'(test_delay[t]);
                repeat (5) @(posedge clk_32f);
                // monitor starts over while the DUT is still held in reset
                exp_q.delete();
                rx_count = 0;
                active_seen = 0;
                last_pulse = -100;
                test_reset <= 1'b0;

                @(negedge clk_32f);
                checks++;
                if (active !== 1'b0) begin
                    $display("ERR %0t active got %b expected 0", $time, active);
                    errors++;
                end
                if (valid_out !== 1'b0) begin
                    $display("ERR %0t valid_out got %b expected 0", $time, valid_out);
                    errors++;
                end
                // idle line carries the comma msb first
                @(posedge clk_32f);
                for (int i = 0; i < 32; i++) begin
                    @(negedge clk_32f);
                    checks++;
                    if (serial_out !== COMMA[7 - (i % 8)]) begin
                        $display("ERR %0t serial_out got %b expected %b",
                                 $time, serial_out, COMMA[7 - (i % 8)]);
                        errors++;
                    end
                end

                wait_cnt = 0;
                while (!active_seen && wait_cnt < 200) begin
                    @(negedge clk_32f);
                    wait_cnt++;
                end
                checks++;
                if (!active_seen) begin
                    $display("receiver never became active with loop delay %0d", test_delay[t]);
                    errors++;
                end else if (active_cyc < `LOCK_COUNT * 8) begin
                    $display("receiver active after only %0d cycles", active_cyc);
                    errors++;
                end

                for (int i = 0; i < test_len[t]; i++) begin
                    idle = $urandom % 4;
                    repeat (idle) send_slot(1'b0, 8'h00);
                    exp_q.push_back(test_bytes[pos + i]);
                    send_slot(1'b1, test_bytes[pos + i]);
                end
                send_slot(1'b0, 8'h00);
                pos += test_len[t];

                wait_cnt = 0;
                while (exp_q.size() != 0 && wait_cnt < 100) begin
                    @(negedge clk_32f);
                    wait_cnt++;
                end
                // catch late duplicates
                repeat (24) @(negedge clk_32f);
                checks++;
                if (rx_count != test_len[t]) begin
                    $display("received %0d bytes but sent %0d", rx_count, test_len[t]);
                    errors++;
                end
                $display("test %0d delay %0d bytes %0d: %s", t, test_delay[t], test_len[t],
                         (errors == err_start) ? "ok" : "bad");
            end

            $display("tests %0d checks %0d errors %0d", test_delay.size(), checks, errors);
            if (errors == 0 && test_delay.size() > 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

    // watchdog sized from the pattern file
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("run did not finish within %0d ns", watchdog_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_32f,
    output logic reset
);

    // 40 ns period
    initial begin
        clk_32f = 1'b0;
        forever #20 clk_32f = ~clk_32f;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk_32f);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog/bit_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "phy_link_defines.svh"

module bit_counter (
    input  logic clk_32f,
    input  logic reset,
    input  logic realign,
    output logic byte_tick
);

    logic [`BIT_CNT_WIDTH-1:0] count;

    // position zero marks the byte slot
    assign byte_tick = (count == '0);

    always_ff @(posedge clk_32f) begin
        if (reset) begin
            count <= '0;
        end else if (realign) begin
            // current cycle becomes position zero
            count <= `BIT_CNT_WIDTH'(1);
        end else if (count == `BIT_CNT_WIDTH'(`BYTE_WIDTH - 1)) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/par_to_serial.sv
`timescale 1ns/10ps
`default_nettype none

`include "phy_link_defines.svh"

module par_to_serial (
    input  logic       clk_32f,
    input  logic       reset,
    input  logic       byte_tick,
    input  logic [7:0] data_in,
    input  logic       valid_in,
    output logic       serial_out
);

    import phy_link_pkg::*;

    symbol_kind_t           load_kind;
    logic [`BYTE_WIDTH-1:0] load_byte;
    logic [`BYTE_WIDTH-1:0] shift_reg;

    //////////////////////////////
    // symbol selection
    //////////////////////////////

    // an empty slot still has to carry something, so send the comma
    assign load_kind = valid_in ? sym_data : sym_comma;
    assign load_byte = (load_kind == sym_data) ? data_in : `COMMA_SYMBOL;

    //////////////////////////////
    // msb first shifter
    //////////////////////////////

    always_ff @(posedge clk_32f) begin
        if (reset) begin
            // line idles on the comma
            shift_reg <= `COMMA_SYMBOL;
        end else if (byte_tick) begin
            shift_reg <= load_byte;
        end else begin
            shift_reg <= {shift_reg[`BYTE_WIDTH-2:0], 1'b0};
        end
    end

    assign serial_out = shift_reg[`BYTE_WIDTH-1];

endmodule

`default_nettype wire

//--- verilog/phy_link.sv
`timescale 1ns/10ps
`default_nettype none

module phy_link (
    input  logic       clk_32f,
    input  logic       reset,
    // transmit side
    input  logic [7:0] data_in,
    input  logic       valid_in,
    output logic       serial_out,
    // receive side
    input  logic       serial_in,
    output logic [7:0] data_out,
    output logic       valid_out,
    output logic       active
);

    logic tx_byte_tick;

    rx_align_if rx_align ();

    //////////////////////////////
    // transmit path
    //////////////////////////////

    // free running byte slots, never realigned
    bit_counter tx_counter (
        .clk_32f   (clk_32f),
        .reset     (reset),
        .realign   (1'b0),
        .byte_tick (tx_byte_tick)
    );

    par_to_serial tx_serializer (
        .clk_32f    (clk_32f),
        .reset      (reset),
        .byte_tick  (tx_byte_tick),
        .data_in    (data_in),
        .valid_in   (valid_in),
        .serial_out (serial_out)
    );

    //////////////////////////////
    // receive path
    //////////////////////////////

    serial_to_par rx_shifter (
        .clk_32f   (clk_32f),
        .reset     (reset),
        .serial_in (serial_in),
        .align     (rx_align.shifter)
    );

    // boundary follows the comma found by the synchronizer
    bit_counter rx_counter (
        .clk_32f   (clk_32f),
        .reset     (reset),
        .realign   (rx_align.realign),
        .byte_tick (rx_align.byte_tick)
    );

    rx_sync_fsm rx_sync (
        .clk_32f   (clk_32f),
        .reset     (reset),
        .align     (rx_align.sync),
        .data_out  (data_out),
        .valid_out (valid_out),
        .active    (active)
    );

endmodule

`default_nettype wire

//--- verilog/phy_link_defines.svh
`ifndef PHY_LINK_DEFINES_SVH
`define PHY_LINK_DEFINES_SVH

// idle / alignment symbol sent when no data is offered
`define COMMA_SYMBOL 8'hBC

// bits per symbol on the serial line
`define BYTE_WIDTH 8

// bit position counter width, log2 of BYTE_WIDTH
`define BIT_CNT_WIDTH 3

// commas on consecutive boundaries before the link is declared active
`define LOCK_COUNT 4

`endif

//--- verilog/phy_link_pkg.sv
`default_nettype none

package phy_link_pkg;

    //////////////////////////////
    // receive synchronizer
    //////////////////////////////

    // hunt for a comma, confirm it on byte boundaries, then pass data
    typedef enum logic [1:0] {
        sync_hunt   = 2'd0,
        sync_check  = 2'd1,
        sync_active = 2'd2
    } sync_state_t;

    //////////////////////////////
    // symbols on the line
    //////////////////////////////

    // what a byte slot carries
    typedef enum logic {
        sym_data  = 1'b0,
        sym_comma = 1'b1
    } symbol_kind_t;

endpackage

`default_nettype wire

//--- verilog/rx_align_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "phy_link_defines.svh"

interface rx_align_if;

    // last eight received bits, newest in bit 0
    logic [`BYTE_WIDTH-1:0] word;
    logic                   comma_hit;
    // byte boundary from the receive counter
    logic                   byte_tick;
    // move the byte boundary to the current window
    logic                   realign;

    modport shifter (
        output word,
        output comma_hit
    );

    modport counter (
        input  realign,
        output byte_tick
    );

    modport sync (
        input  word,
        input  comma_hit,
        input  byte_tick,
        output realign
    );

endinterface

`default_nettype wire

//--- verilog/rx_sync_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "phy_link_defines.svh"

module rx_sync_fsm (
    input  logic       clk_32f,
    input  logic       reset,
    rx_align_if.sync   align,
    output logic [7:0] data_out,
    output logic       valid_out,
    output logic       active
);

    import phy_link_pkg::*;

    localparam int LOCK_W = $clog2(`LOCK_COUNT + 1);

    sync_state_t  state;
    symbol_kind_t word_kind;
    logic [LOCK_W-1:0] lock_cnt;

    assign word_kind = align.comma_hit ? sym_comma : sym_data;

    // first comma seen while hunting defines the byte boundary
    assign align.realign = (state == sync_hunt) && (word_kind == sym_comma);

    assign active = (state == sync_active);

    //////////////////////////////
    // lock state machine
    //////////////////////////////

    always_ff @(posedge clk_32f) begin
        if (reset) begin
            state    <= sync_hunt;
            lock_cnt <= '0;
        end else begin
            case (state)
                sync_hunt: begin
                    if (word_kind == sym_comma) begin
                        lock_cnt <= LOCK_W'(1);
                        state    <= sync_check;
                    end
                end
                sync_check: begin
                    if (align.byte_tick) begin
                        if (word_kind != sym_comma) begin
                            // boundary was a false hit
                            lock_cnt <= '0;
                            state    <= sync_hunt;
                        end else if (lock_cnt == LOCK_W'(`LOCK_COUNT - 1)) begin
                            lock_cnt <= lock_cnt + 1'b1;
                            state    <= sync_active;
                        end else begin
                            lock_cnt <= lock_cnt + 1'b1;
                        end
                    end
                end
                sync_active: begin
                    // lock is held once reached
                    state <= sync_active;
                end
                default: begin
                    state <= sync_hunt;
                end
            endcase
        end
    end

    //////////////////////////////
    // data delivery
    //////////////////////////////

    always_ff @(posedge clk_32f) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= active && align.byte_tick && (word_kind == sym_data);
        end
    end

    // payload only, qualified by valid_out
    always_ff @(posedge clk_32f) begin
        if (active && align.byte_tick && (word_kind == sym_data)) begin
            data_out <= align.word;
        end
    end

endmodule

`default_nettype wire

//--- verilog/serial_to_par.sv
`timescale 1ns/10ps
`default_nettype none

`include "phy_link_defines.svh"

module serial_to_par (
    input  logic       clk_32f,
    input  logic       reset,
    input  logic       serial_in,
    rx_align_if.shifter align
);

    logic [`BYTE_WIDTH-1:0] shift_reg;

    //////////////////////////////
    // receive window
    //////////////////////////////

    // one bit per clock, oldest bit falls off the top
    always_ff @(posedge clk_32f) begin
        if (reset) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= {shift_reg[`BYTE_WIDTH-2:0], serial_in};
        end
    end

    assign align.word = shift_reg;

    // comma at whatever offset the window currently sits
    assign align.comma_hit = (shift_reg == `COMMA_SYMBOL);

endmodule

`default_nettype wire
